// ==== Makefile ====
# Verilator build and run of the uart to i2c bridge testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module tb_uart_i2c_bridge \
		-f uart_i2c_bridge.f --Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/bridge_pkg.sv ====
// uart to i2c bridge shared definitions
// timing constants, command codes, state encodings and the i2c item type
package bridge_pkg;

    // uart bit timing in clk cycles
    localparam int uart_clks_per_bit = 16;
    localparam int uart_cnt_w = $clog2(uart_clks_per_bit);
    // reload values for the bit timer, full bit and half bit
    localparam logic [uart_cnt_w-1:0] uart_full_bit = uart_cnt_w'(uart_clks_per_bit - 1);
    localparam logic [uart_cnt_w-1:0] uart_half_bit = uart_cnt_w'(uart_clks_per_bit / 2 - 1);

    // one scl period is four quarters
    localparam int i2c_clks_per_quarter = 4;
    localparam int i2c_cnt_w = $clog2(i2c_clks_per_quarter);
    localparam logic [i2c_cnt_w-1:0] i2c_quarter_end = i2c_cnt_w'(i2c_clks_per_quarter - 1);

    // packet limits
    localparam int max_payload = 16;
    // buffer holds address plus payload
    localparam int buf_idx_w = $clog2(max_payload + 1);
    localparam logic [7:0] max_count = 8'(max_payload);

    // item fifo depth, power of two
    localparam int fifo_depth = 32;

    // host command bytes
    typedef enum logic [7:0] {
        cmd_start = 8'h53,
        cmd_stop  = 8'h50
    } cmd_code_t;

    typedef enum logic [2:0] {
        wait_start,
        get_addr,
        get_count,
        get_data,
        wait_stop,
        discard
    } parser_state_t;

    typedef enum logic [2:0] {
        idle,
        start_cond,
        shift_byte,
        ack_bit,
        stop_cond
    } i2c_state_t;

    // one byte on the i2c bus plus transaction framing
    typedef struct packed {
        logic [7:0] data;
        logic       first;
        logic       last;
    } i2c_item_t;

endpackage

// ==== hw/byte_fifo.sv ====
// synchronous item fifo, valid/ready on both sides
// depth must be a power of two, pointers wrap on their own
`timescale 1ns/1ps
module byte_fifo #(
    parameter int depth = bridge_pkg::fifo_depth
) (
    input  logic                  clk,
    input  logic                  reset,
    input  bridge_pkg::i2c_item_t in_item,
    input  logic                  in_valid,
    output logic                  in_ready,
    output bridge_pkg::i2c_item_t out_item,
    output logic                  out_valid,
    input  logic                  out_ready
);

    bridge_pkg::i2c_item_t    mem [depth];
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    // one extra bit so full is distinct from empty
    logic [$clog2(depth):0]   count;
    logic                     wr_en;
    logic                     rd_en;

    // msb of count set only at depth entries
    assign in_ready  = ~count[$clog2(depth)];
    assign out_valid = |count;
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_item;
        end
    end

    // head of queue
    assign out_item = mem[rd_ptr];

endmodule

// ==== hw/cmd_parser.sv ====
// host command parser, checks S addr count data P packets
// buffers a packet and replays it as i2c items once the closing P is seen
`timescale 1ns/1ps
module cmd_parser (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [7:0]            rx_data,
    input  logic                  rx_valid,
    output bridge_pkg::i2c_item_t item,
    output logic                  item_valid,
    input  logic                  item_ready
);

    bridge_pkg::parser_state_t        state;
    // address at index 0, payload after it
    logic [7:0]                       pkt_buf [0:bridge_pkg::max_payload];
    logic [bridge_pkg::buf_idx_w-1:0] wr_idx;
    logic [bridge_pkg::buf_idx_w-1:0] rd_idx;
    logic [bridge_pkg::buf_idx_w-1:0] last_idx;
    // data bytes still expected
    logic [7:0]                       remaining;
    logic                             pushing;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= bridge_pkg::wait_start;
            pushing   <= 1'b0;
            wr_idx    <= '0;
            rd_idx    <= '0;
            last_idx  <= '0;
            remaining <= '0;
        end else begin
            // replay, one item per accepted handshake
            if (item_valid && item_ready) begin
                if (rd_idx == last_idx) begin
                    pushing <= 1'b0;
                end else begin
                    rd_idx <= rd_idx + 1'b1;
                end
            end

            if (rx_valid) begin
                case (state)
                    bridge_pkg::wait_start: begin
                        // stray bytes are ignored here
                        if (rx_data == bridge_pkg::cmd_start) begin
                            wr_idx <= '0;
                            state  <= bridge_pkg::get_addr;
                        end
                    end
                    bridge_pkg::get_addr: begin
                        wr_idx <= wr_idx + 1'b1;
                        // reads not supported, skip to P
                        if (rx_data[0]) begin
                            state <= bridge_pkg::discard;
                        end else begin
                            state <= bridge_pkg::get_count;
                        end
                    end
                    bridge_pkg::get_count: begin
                        if ((rx_data == 8'd0) || (rx_data > bridge_pkg::max_count)) begin
                            state <= bridge_pkg::discard;
                        end else begin
                            remaining <= rx_data;
                            state     <= bridge_pkg::get_data;
                        end
                    end
                    bridge_pkg::get_data: begin
                        wr_idx    <= wr_idx + 1'b1;
                        remaining <= remaining - 1'b1;
                        if (remaining == 8'd1) begin
                            state <= bridge_pkg::wait_stop;
                        end
                    end
                    bridge_pkg::wait_stop: begin
                        // wrong terminator drops the whole packet
                        if (rx_data == bridge_pkg::cmd_stop) begin
                            pushing  <= 1'b1;
                            rd_idx   <= '0;
                            last_idx <= wr_idx - 1'b1;
                        end
                        state <= bridge_pkg::wait_start;
                    end
                    bridge_pkg::discard: begin
                        if (rx_data == bridge_pkg::cmd_stop) begin
                            state <= bridge_pkg::wait_start;
                        end
                    end
                    default: begin
                        state <= bridge_pkg::wait_start;
                    end
                endcase
            end
        end
    end

    // packet storage
    always_ff @(posedge clk) begin
        if (rx_valid && ((state == bridge_pkg::get_addr) || (state == bridge_pkg::get_data))) begin
            pkt_buf[wr_idx] <= rx_data;
        end
    end

    // item framing from the replay index
    assign item.data  = pkt_buf[rd_idx];
    assign item.first = (rd_idx == '0);
    assign item.last  = (rd_idx == last_idx);
    assign item_valid = pushing;

endmodule

// ==== hw/i2c/i2c_master.sv ====
// i2c write master, start, msb first bytes with ack slot, stop
// scl period built from four quarter phases, nack ends the transfer early
`timescale 1ns/1ps
module i2c_master (
    input  logic                  clk,
    input  logic                  reset,
    input  bridge_pkg::i2c_item_t item,
    input  logic                  item_valid,
    output logic                  item_ready,
    input  logic                  sdarx,
    output logic                  sdatx,
    output logic                  scl
);

    bridge_pkg::i2c_state_t           state;
    logic [bridge_pkg::i2c_cnt_w-1:0] q_cnt;
    // quarter index within the scl period
    logic [1:0]                       phase;
    logic [2:0]                       bit_cnt;
    logic [7:0]                       shreg;
    logic                             cur_last;
    logic                             nack;
    // skip rest of a transaction after nack
    logic                             drain;
    logic                             tick;
    logic                             period_end;
    logic                             ack_next;
    logic                             stall;
    logic                             load;
    logic                             scl_next;
    logic                             sda_next;

    assign tick       = (q_cnt == bridge_pkg::i2c_quarter_end);
    assign period_end = tick && (phase == 2'd3);
    // ack slot done and more bytes follow
    assign ack_next   = (state == bridge_pkg::ack_bit) && period_end && !nack && !cur_last;
    // hold scl low until the next byte shows up
    assign stall      = ack_next && !item_valid;
    assign load       = ((state == bridge_pkg::idle) && item_valid && item.first && !drain)
                        || (ack_next && item_valid);

    assign item_ready = ((state == bridge_pkg::idle) && (drain || item.first)) || ack_next;

    // pin levels per state and quarter
    always_comb begin
        case (state)
            bridge_pkg::start_cond: begin
                // sda falls in quarter 1 with scl high
                scl_next = (phase != 2'd3);
                sda_next = (phase == 2'd0);
            end
            bridge_pkg::shift_byte: begin
                scl_next = (phase == 2'd1) || (phase == 2'd2);
                sda_next = shreg[7];
            end
            bridge_pkg::ack_bit: begin
                // released for the slave
                scl_next = (phase == 2'd1) || (phase == 2'd2);
                sda_next = 1'b1;
            end
            bridge_pkg::stop_cond: begin
                // sda rises in quarter 2 with scl high
                scl_next = (phase != 2'd0);
                sda_next = phase[1];
            end
            default: begin
                scl_next = 1'b1;
                sda_next = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state    <= bridge_pkg::idle;
            q_cnt    <= '0;
            phase    <= '0;
            bit_cnt  <= '0;
            cur_last <= 1'b0;
            nack     <= 1'b0;
            drain    <= 1'b0;
            scl      <= 1'b1;
            sdatx    <= 1'b1;
        end else begin
            scl   <= scl_next;
            sdatx <= sda_next;

            // quarter timer
            if (state == bridge_pkg::idle) begin
                q_cnt <= '0;
                phase <= '0;
            end else if (!stall) begin
                q_cnt <= tick ? '0 : q_cnt + 1'b1;
                if (tick) begin
                    phase <= phase + 1'b1;
                end
            end

            if (load) begin
                cur_last <= item.last;
            end

            case (state)
                bridge_pkg::idle: begin
                    if (item_valid && drain) begin
                        if (item.last) begin
                            drain <= 1'b0;
                        end
                    end else if (load) begin
                        state <= bridge_pkg::start_cond;
                    end
                end
                bridge_pkg::start_cond: begin
                    if (period_end) begin
                        bit_cnt <= '0;
                        state   <= bridge_pkg::shift_byte;
                    end
                end
                bridge_pkg::shift_byte: begin
                    if (period_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= bridge_pkg::ack_bit;
                        end
                    end
                end
                bridge_pkg::ack_bit: begin
                    // same edge that raises scl
                    if ((phase == 2'd1) && (q_cnt == '0)) begin
                        nack <= sdarx;
                    end
                    if (period_end) begin
                        if (nack || cur_last) begin
                            drain <= nack && !cur_last;
                            state <= bridge_pkg::stop_cond;
                        end else if (item_valid) begin
                            state <= bridge_pkg::shift_byte;
                        end
                    end
                end
                bridge_pkg::stop_cond: begin
                    if (period_end) begin
                        state <= bridge_pkg::idle;
                    end
                end
                default: begin
                    state <= bridge_pkg::idle;
                end
            endcase
        end
    end

    // byte shifter, msb first
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= item.data;
        end else if ((state == bridge_pkg::shift_byte) && period_end) begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

endmodule

// ==== hw/uart/uart_rx.sv ====
// uart receiver, 8N1, lsb first, oversampled by the bit timer
// strobes rx_valid for one cycle per byte with a good stop bit
`timescale 1ns/1ps
module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    logic                              rx_meta;
    logic                              rx_sync;
    logic                              rx_prev;
    logic                              busy;
    logic [bridge_pkg::uart_cnt_w-1:0] clk_cnt;
    // 0 start, 1..8 data, 9 stop
    logic [3:0]                        bit_idx;
    logic [7:0]                        shreg;
    logic                              sample;

    // two flop synchronizer, plus one more for edge detect
    always_ff @(posedge clk) begin
        if (!reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // mid-bit sample point
    assign sample = busy && (clk_cnt == '0);

    always_ff @(posedge clk) begin
        if (!reset) begin
            busy     <= 1'b0;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!busy) begin
                // falling edge only, a stuck low line after a bad stop is ignored
                if (rx_prev && !rx_sync) begin
                    busy    <= 1'b1;
                    clk_cnt <= bridge_pkg::uart_half_bit;
                    bit_idx <= '0;
                end
            end else if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= bridge_pkg::uart_full_bit;
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0) begin
                    // start bit gone at half bit, treat as glitch
                    if (rx_sync) begin
                        busy <= 1'b0;
                    end
                end else if (bit_idx == 4'd9) begin
                    busy <= 1'b0;
                    // framing check
                    rx_valid <= rx_sync;
                end
            end
        end
    end

    // data bits arrive lsb first, shift in from the top
    always_ff @(posedge clk) begin
        if (sample && (bit_idx != 4'd0) && (bit_idx != 4'd9)) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
    end

    // shreg is stable during the stop bit strobe
    assign rx_data = shreg;

endmodule

// ==== hw/uart_i2c_bridge.sv ====
// uart to i2c write bridge top
// receiver, packet parser, item fifo and i2c master in a chain
`timescale 1ns/1ps
module uart_i2c_bridge (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    input  logic sdarx,
    output logic sdatx,
    output logic scl
);

    logic [7:0]            rx_data;
    logic                  rx_valid;
    // parser to fifo
    bridge_pkg::i2c_item_t in_item;
    logic                  in_valid;
    logic                  in_ready;
    // fifo to master
    bridge_pkg::i2c_item_t out_item;
    logic                  out_valid;
    logic                  out_ready;

    uart_rx uart_rx_inst (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    cmd_parser cmd_parser_inst (
        .clk        (clk),
        .reset      (reset),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .item       (in_item),
        .item_valid (in_valid),
        .item_ready (in_ready)
    );

    byte_fifo #(
        .depth (bridge_pkg::fifo_depth)
    ) byte_fifo_inst (
        .clk       (clk),
        .reset     (reset),
        .in_item   (in_item),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_item  (out_item),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    i2c_master i2c_master_inst (
        .clk        (clk),
        .reset      (reset),
        .item       (out_item),
        .item_valid (out_valid),
        .item_ready (out_ready),
        .sdarx      (sdarx),
        .sdatx      (sdatx),
        .scl        (scl)
    );

endmodule

// ==== tests/bridge_checker.sv ====
// i2c bus checker for the uart to i2c bridge
// decodes scl/sda into transactions and compares them with reference packets
// expects both lines high whenever no transaction is open
`timescale 1ns/1ps
module bridge_checker (
    input  logic clk,
    input  logic reset,
    input  logic scl,
    input  logic sdatx,
    output int   errors,
    output int   pending,
    output logic busy
);

    // expected transactions with their bytes flattened in order
    logic [7:0] exp_bytes [$];
    int         exp_len [$];
    string      exp_name [$];
    // bytes seen in the current transaction
    logic [7:0] got [0:31];
    int         got_n;
    int         nbits;
    logic [7:0] shreg;
    logic       prev_scl;
    logic       prev_sda;
    // test named in pin level reports
    string      cur_test;
    // set while a bad idle level is already reported
    logic       idle_bad;

    // expected i2c bytes for one host byte stream or 0 when the bus must stay quiet
    function automatic int ref_txn(input logic [7:0] s [0:39], input int n,
                                   input logic nack, output logic [7:0] q [0:16]);
        int st;
        int left;
        int k;
        int i;
        // 0 wait S, 1 addr, 2 count, 3 data, 4 stop, 5 discard to P
        st = 0;
        left = 0;
        k = 0;
        for (i = 0; i < n; i++) begin
            case (st)
                0: begin
                    if (s[i] == 8'h53) st = 1;
                end
                1: begin
                    q[0] = s[i];
                    k = 1;
                    // reads are dropped
                    st = s[i][0] ? 5 : 2;
                end
                2: begin
                    if (s[i] == 8'd0 || s[i] > 8'd16) begin
                        st = 5;
                    end else begin
                        left = int'(s[i]);
                        st = 3;
                    end
                end
                3: begin
                    q[k] = s[i];
                    k++;
                    left--;
                    if (left == 0) st = 4;
                end
                4: begin
                    // nack on the address leaves only the address on the bus
                    if (s[i] == 8'h50) return nack ? 1 : k;
                    st = 0;
                end
                default: begin
                    if (s[i] == 8'h50) st = 0;
                end
            endcase
        end
        return 0;
    endfunction

    task automatic start_test(input string name);
        cur_test = name;
    endtask

    task automatic expect_packet(input string name, input logic [7:0] s [0:39],
                                 input int n, input logic nack);
        logic [7:0] q [0:16];
        int         len;
        int         i;
        len = ref_txn(s, n, nack, q);
        if (len > 0) begin
            for (i = 0; i < len; i++) begin
                exp_bytes.push_back(q[i]);
            end
            exp_len.push_back(len);
            exp_name.push_back(name);
        end
    endtask

    task automatic compare_txn();
        logic [7:0] e;
        int         len;
        int         i;
        string      name;
        if (exp_len.size() == 0) begin
            $display("extra transaction with %0d bytes on the bus, none was expected", got_n);
            errors++;
        end else begin
            len = exp_len.pop_front();
            name = exp_name.pop_front();
            if (got_n != len) begin
                $display("%s: transaction carried %0d bytes instead of %0d", name, got_n, len);
                errors++;
            end
            for (i = 0; i < len; i++) begin
                e = exp_bytes.pop_front();
                if (i < got_n && got[i] !== e) begin
                    $display("CHECK FAILED %s byte %0d expected 0x%02h actual 0x%02h",
                             name, i, e, got[i]);
                    errors++;
                end
            end
        end
    endtask

    // pins change on rising clk edges and are stable at the falling one
    always @(negedge clk) begin
        if (!reset) begin
            busy = 1'b0;
            nbits = 0;
            got_n = 0;
            errors = 0;
            idle_bad = 1'b0;
        end else if (scl && prev_scl && prev_sda && !sdatx) begin
            // start when sda falls with scl high
            busy = 1'b1;
            nbits = 0;
            got_n = 0;
        end else if (scl && prev_scl && !prev_sda && sdatx && busy) begin
            // stop ends the transaction
            busy = 1'b0;
            compare_txn();
        end else if (scl && !prev_scl && busy) begin
            if (nbits < 8) begin
                shreg = {shreg[6:0], sdatx};
                nbits++;
            end else begin
                // ack slot closes the byte
                if (got_n < 32) got[got_n] = shreg;
                got_n++;
                nbits = 0;
            end
        end
        // released bus between transactions
        if (reset && !busy) begin
            if (scl !== 1'b1 || sdatx !== 1'b1) begin
                if (!idle_bad) begin
                    $display("CHECK FAILED %s expected scl,sda 11 actual %b%b",
                             cur_test, scl, sdatx);
                    errors++;
                end
                idle_bad = 1'b1;
            end else begin
                idle_bad = 1'b0;
            end
        end
        prev_scl = scl;
        prev_sda = sdatx;
        pending = exp_len.size();
    end

endmodule

// ==== tests/tb_uart_i2c_bridge.sv ====
// testbench for the uart to i2c bridge
// serial host driver, i2c slave ack model and the test sequence
`timescale 1ns/1ps
module tb_uart_i2c_bridge;

    logic       clk;
    logic       reset;
    logic       rx;
    logic       sdarx;
    logic       sdatx;
    logic       scl;
    int         errors;
    int         pending;
    logic       busy;
    int         seed;
    int         tests;
    int         failing;
    int         base;
    // waits that gave up
    int         timeouts;
    logic       nack_on;
    logic [6:0] nack_addr;
    // host byte stream of the current step
    logic [7:0] seq [0:39];
    int         seq_n;
    int         i;
    int         cnt;
    int         bad;
    logic [6:0] addr;
    // slave model state
    logic       sl_prev_scl;
    logic       sl_prev_sda;
    int         sl_bits;
    logic       sl_first;
    logic [7:0] sl_byte;

    uart_i2c_bridge uart_i2c_bridge_inst (
        .clk   (clk),
        .reset (reset),
        .rx    (rx),
        .sdarx (sdarx),
        .sdatx (sdatx),
        .scl   (scl)
    );

    bridge_checker bridge_checker_inst (
        .clk     (clk),
        .reset   (reset),
        .scl     (scl),
        .sdatx   (sdatx),
        .errors  (errors),
        .pending (pending),
        .busy    (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // slave model acks every ack slot except for the selected nack address
    initial begin
        sdarx = 1'b1;
        sl_prev_scl = 1'b1;
        sl_prev_sda = 1'b1;
        sl_bits = 0;
        sl_first = 1'b0;
        sl_byte = '0;
        forever begin
            @(negedge clk);
            if (scl && sl_prev_scl && sl_prev_sda && !sdatx) begin
                sl_bits = 0;
                sl_first = 1'b1;
            end else if (scl && !sl_prev_scl) begin
                sl_byte = {sl_byte[6:0], sdatx};
                sl_bits++;
            end else if (!scl && sl_prev_scl) begin
                if (sl_bits == 8) begin
                    sdarx = sl_first && nack_on && (sl_byte[7:1] == nack_addr);
                end else begin
                    sdarx = 1'b1;
                    if (sl_bits == 9) begin
                        sl_bits = 0;
                        sl_first = 1'b0;
                    end
                end
            end
            sl_prev_scl = scl;
            sl_prev_sda = sdatx;
        end
    end

    // 8N1 lsb first with an optional low stop bit
    task automatic send_byte(input logic [7:0] b, input logic bad_stop);
        int k;
        @(negedge clk);
        rx = 1'b0;
        repeat (bridge_pkg::uart_clks_per_bit) @(negedge clk);
        for (k = 0; k < 8; k++) begin
            rx = b[k];
            repeat (bridge_pkg::uart_clks_per_bit) @(negedge clk);
        end
        rx = !bad_stop;
        repeat (bridge_pkg::uart_clks_per_bit) @(negedge clk);
        if (bad_stop) begin
            // idle bit so the next start bit has an edge
            rx = 1'b1;
            repeat (bridge_pkg::uart_clks_per_bit) @(negedge clk);
        end
    endtask

    task automatic add_byte(input logic [7:0] b);
        seq[seq_n] = b;
        seq_n++;
    endtask

    // S, address, count, data, stop byte
    task automatic add_pkt(input logic [7:0] a, input logic [7:0] c, input int ndata,
                           input logic [7:0] stop, input logic [7:0] mask);
        int k;
        add_byte(8'h53);
        add_byte(a);
        add_byte(c);
        for (k = 0; k < ndata; k++) begin
            add_byte(8'($random(seed)) & mask);
        end
        add_byte(stop);
    endtask

    // the byte at bad_idx gets a low stop bit and never reaches the parser
    task automatic run_stream(input string name, input int bad_idx, input logic nack);
        logic [7:0] good [0:39];
        int         n;
        int         k;
        n = 0;
        for (k = 0; k < seq_n; k++) begin
            if (k != bad_idx) begin
                good[n] = seq[k];
                n++;
            end
        end
        nack_on = nack;
        @(posedge clk);
        bridge_checker_inst.expect_packet(name, good, n, nack);
        for (k = 0; k < seq_n; k++) begin
            send_byte(seq[k], k == bad_idx);
        end
        seq_n = 0;
    endtask

    // bus idle and nothing outstanding for a while
    task automatic wait_quiet(input string name);
        int quiet;
        int cycles;
        quiet = 0;
        cycles = 0;
        while (quiet < 300 && cycles < 20000) begin
            @(posedge clk);
            cycles++;
            if (busy || pending != 0) quiet = 0;
            else quiet++;
        end
        if (quiet < 300) begin
            $display("timeout in %s, %0d expected transactions never finished", name, pending);
            timeouts++;
        end
    endtask

    task automatic begin_test(input string name);
        @(posedge clk);
        bridge_checker_inst.start_test(name);
        base = errors + timeouts;
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        tests++;
        if (errors + timeouts > base) begin
            failing++;
            $display("test %s: FAIL", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        seed = 32'hd300_95b5;
        rx = 1'b1;
        reset = 1'b0;
        nack_on = 1'b0;
        nack_addr = 7'h3c;
        tests = 0;
        failing = 0;
        timeouts = 0;
        seq_n = 0;
        repeat (8) @(negedge clk);
        reset = 1'b1;

        // pins stay high and no transaction appears with rx idle
        begin_test("reset_idle");
        wait_quiet("reset_idle");
        end_test("reset_idle");

        begin_test("single_byte");
        add_pkt(8'h24, 8'd1, 1, 8'h50, 8'hff);
        run_stream("single_byte", -1, 1'b0);
        wait_quiet("single_byte");
        end_test("single_byte");

        // no gap between packets
        begin_test("back_to_back");
        for (i = 0; i < 6; i++) begin
            addr = 7'($random(seed));
            if (addr == nack_addr) addr = addr ^ 7'h01;
            cnt = 1 + int'($unsigned($random(seed)) % 16);
            add_pkt({addr, 1'b0}, 8'(cnt), cnt, 8'h50, 8'hff);
            run_stream("back_to_back", -1, 1'b0);
        end
        wait_quiet("back_to_back");
        end_test("back_to_back");

        // masked data keeps 0x50 and 0x53 out of dropped packets
        begin_test("discard");
        add_byte(8'h00);
        add_byte(8'h41);
        add_byte(8'h50);
        add_pkt(8'h21, 8'd2, 2, 8'h50, 8'h3f);
        add_pkt(8'h20, 8'd0, 0, 8'h50, 8'h3f);
        add_pkt(8'h20, 8'd17, 0, 8'h50, 8'h3f);
        add_pkt(8'h20, 8'd1, 1, 8'h51, 8'h3f);
        bad = seq_n + 3;
        add_pkt(8'h20, 8'd2, 2, 8'h50, 8'h3f);
        // flush byte since the parser is left waiting for a stop byte
        add_byte(8'h00);
        run_stream("discard", bad, 1'b0);
        wait_quiet("discard");
        end_test("discard");

        begin_test("nack");
        add_pkt({nack_addr, 1'b0}, 8'd3, 3, 8'h50, 8'hff);
        run_stream("nack_addr", -1, 1'b1);
        wait_quiet("nack_addr");
        add_pkt(8'h24, 8'd4, 4, 8'h50, 8'hff);
        run_stream("after_nack", -1, 1'b0);
        wait_quiet("after_nack");
        end_test("nack");

        $display("summary: %0d tests, %0d failing, %0d errors, %0d timeouts", tests, failing,
                 errors, timeouts);
        if (failing == 0 && errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== uart_i2c_bridge.f ====
common/bridge_pkg.sv
hw/uart/uart_rx.sv
hw/cmd_parser.sv
hw/byte_fifo.sv
hw/i2c/i2c_master.sv
hw/uart_i2c_bridge.sv
tests/bridge_checker.sv
tests/tb_uart_i2c_bridge.sv
